// ==== design/isa_pkg.sv ====
package isa_pkg;

	localparam int reg_index_width = 4; // sixteen architectural registers.
	localparam int word_width = 16;
	localparam int imm_width = 8;

	// top bit of the opcode selects the immediate format.
	typedef enum logic [3:0] {
		op_add  = 4'h0,
		op_sub  = 4'h1,
		op_and  = 4'h2,
		op_or   = 4'h3,
		op_addi = 4'h8,
		op_li   = 4'h9,
		op_andi = 4'ha,
		op_ori  = 4'hb
	} opcode_t;

	typedef struct packed {
		opcode_t opcode;
		logic [reg_index_width-1:0] dest;
		logic [reg_index_width-1:0] src1;
		logic [reg_index_width-1:0] src2;
	} reg_format_t;

	typedef struct packed {
		opcode_t opcode;
		logic [reg_index_width-1:0] dest;
		logic [imm_width-1:0] imm;
	} imm_format_t;

	typedef union packed {
		reg_format_t reg_fmt;
		imm_format_t imm_fmt;
	} instr_word_t;

endpackage

// ==== design/rob_pkg.sv ====
package rob_pkg;

	// ******************************
	// group geometry
	// ******************************

	localparam int lanes = 3; // lane 2 is the oldest.

	localparam int value_width = 16;

	// ******************************
	// reorder buffer entry
	// ******************************

	// completed marks an entry that may leave the head.
	// immediate entries are written with completed already set.
	typedef struct packed {
		logic [isa_pkg::reg_index_width-1:0] dest;
		logic [value_width-1:0] value;
		logic completed;
		logic is_imm;
	} rob_entry_t;

endpackage

// ==== design/rob_ifs.sv ====
`timescale 1ns/1ps

// dispatch to reorder buffer.
interface alloc_if #(
	parameter int rob_depth = 8
);
	localparam int tag_width = $clog2(rob_depth);

	logic [rob_pkg::lanes-1:0] valid; // contiguous from lane 2 down.
	rob_pkg::rob_entry_t [rob_pkg::lanes-1:0] entries;
	logic accept; // group moves when high with any valid bit.
	logic [rob_pkg::lanes-1:0][tag_width-1:0] tags;

	modport producer (
		output valid,
		output entries,
		input accept,
		input tags
	);

	modport consumer (
		input valid,
		input entries,
		output accept,
		output tags
	);
endinterface

// reorder buffer to retire stage, no back-pressure.
interface retire_if;
	logic [rob_pkg::lanes-1:0] valid;
	rob_pkg::rob_entry_t [rob_pkg::lanes-1:0] entries;

	modport producer (
		output valid,
		output entries
	);

	modport consumer (
		input valid,
		input entries
	);
endinterface

// ==== design/dispatch_stage.sv ====
`timescale 1ns/1ps

module dispatch_stage (
	input logic clock,
	input logic reset,
	input logic [rob_pkg::lanes-1:0] in_valid,
	input isa_pkg::instr_word_t [rob_pkg::lanes-1:0] in_words,
	output logic in_ready,
	alloc_if.producer alloc
);

	rob_pkg::rob_entry_t [rob_pkg::lanes-1:0] decoded;
	rob_pkg::rob_entry_t [rob_pkg::lanes-1:0] held_entries;
	logic [rob_pkg::lanes-1:0] held_valid;
	logic take;

	// ******************************
	// decode
	// ******************************

	always_comb begin
		for (int i = 0; i < rob_pkg::lanes; i++) begin
			decoded[i].is_imm = in_words[i].imm_fmt.opcode[3];
			decoded[i].completed = in_words[i].imm_fmt.opcode[3]; // immediates need no unit.
			decoded[i].dest = in_words[i].reg_fmt.dest; // same field in both formats.
			decoded[i].value = '0;
			if (in_words[i].imm_fmt.opcode[3]) begin
				decoded[i].value[isa_pkg::imm_width-1:0] = in_words[i].imm_fmt.imm; // zero extend.
			end
		end
	end

	// ******************************
	// group holding register
	// ******************************

	// free when empty, or when the held group leaves this cycle.
	assign in_ready = ~(|held_valid) | alloc.accept;
	assign take = in_ready & (|in_valid);

	always_ff @(posedge clock) begin
		if (reset) begin
			held_valid <= '0;
		end else if (in_ready) begin
			held_valid <= in_valid; // empty input clears an accepted group.
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			held_entries <= decoded;
		end
	end

	assign alloc.valid = held_valid;
	assign alloc.entries = held_entries;

endmodule

// ==== design/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer #(
	parameter int rob_depth = 8,
	localparam int tag_width = $clog2(rob_depth),
	localparam int count_width = tag_width + 1
) (
	input logic clock,
	input logic reset,
	alloc_if.consumer alloc,
	input logic [rob_pkg::lanes-1:0] complete_valid,
	input logic [rob_pkg::lanes-1:0][tag_width-1:0] complete_tag,
	input logic [rob_pkg::lanes-1:0][rob_pkg::value_width-1:0] complete_value,
	output logic [rob_pkg::lanes-1:0] alloc_valid,
	output logic [rob_pkg::lanes-1:0][tag_width-1:0] alloc_tag,
	retire_if.producer released
);

	rob_pkg::rob_entry_t entries_q [rob_depth];

	logic [tag_width-1:0] head_q;
	logic [tag_width-1:0] tail_q;
	logic [count_width-1:0] count_q;

	logic [tag_width-1:0] head_pos [rob_pkg::lanes];
	logic [tag_width-1:0] tail_pos [rob_pkg::lanes];
	logic [1:0] rel_n;
	logic [1:0] alloc_n;
	logic [count_width-1:0] free_slots;

	// slot k counts from the oldest, and lands on lane lanes-1-k.
	always_comb begin
		for (int k = 0; k < rob_pkg::lanes; k++) begin
			head_pos[k] = head_q + tag_width'(k);
			tail_pos[k] = tail_q + tag_width'(k);
		end
	end

	// ******************************
	// in-order release from head
	// ******************************

	always_comb begin
		logic run;
		run = 1'b1;
		rel_n = '0;
		released.valid = '0;
		for (int k = 0; k < rob_pkg::lanes; k++) begin
			released.entries[rob_pkg::lanes-1-k] = entries_q[head_pos[k]];
			if (run && count_width'(k) < count_q && entries_q[head_pos[k]].completed) begin
				released.valid[rob_pkg::lanes-1-k] = 1'b1;
				rel_n = rel_n + 2'd1;
			end else begin
				run = 1'b0; // stop at the first entry still waiting.
			end
		end
	end

	// ******************************
	// allocation at tail
	// ******************************

	always_comb begin
		alloc_n = '0;
		for (int i = 0; i < rob_pkg::lanes; i++) begin
			alloc_n = alloc_n + {1'b0, alloc.valid[i]};
		end
	end

	// slots released this cycle count as free.
	assign free_slots = count_width'(rob_depth) - count_q + count_width'(rel_n);
	assign alloc.accept = free_slots >= count_width'(alloc_n); // whole group or nothing.

	always_comb begin
		for (int k = 0; k < rob_pkg::lanes; k++) begin
			alloc.tags[rob_pkg::lanes-1-k] = tail_pos[k];
		end
	end

	assign alloc_valid = alloc.accept ? alloc.valid : '0;
	assign alloc_tag = alloc.tags;

	// ******************************
	// state update
	// ******************************

	always_ff @(posedge clock) begin
		if (reset) begin
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
		end else begin
			head_q <= head_q + tag_width'(rel_n);
			if (alloc.accept) begin
				tail_q <= tail_q + tag_width'(alloc_n);
				count_q <= count_q - count_width'(rel_n) + count_width'(alloc_n);
			end else begin
				count_q <= count_q - count_width'(rel_n);
			end
		end
	end

	// completions are applied after the allocation writes.
	always_ff @(posedge clock) begin
		for (int k = 0; k < rob_pkg::lanes; k++) begin
			if (alloc.accept && alloc.valid[rob_pkg::lanes-1-k]) begin
				entries_q[tail_pos[k]] <= alloc.entries[rob_pkg::lanes-1-k];
			end
		end
		for (int i = 0; i < rob_pkg::lanes; i++) begin
			if (complete_valid[i]) begin
				entries_q[complete_tag[i]].completed <= 1'b1;
				entries_q[complete_tag[i]].value <= complete_value[i];
			end
		end
	end

endmodule

// ==== design/retire_stage.sv ====
`timescale 1ns/1ps

module retire_stage (
	input logic clock,
	input logic reset,
	retire_if.consumer released,
	output logic [rob_pkg::lanes-1:0] retire_valid,
	output logic [rob_pkg::lanes-1:0][isa_pkg::reg_index_width-1:0] retire_dest,
	output logic [rob_pkg::lanes-1:0][rob_pkg::value_width-1:0] retire_value,
	input logic [isa_pkg::reg_index_width-1:0] read_index,
	output logic [rob_pkg::value_width-1:0] read_data
);

	logic [rob_pkg::value_width-1:0] arch_regs [2**isa_pkg::reg_index_width];

	// ******************************
	// commit report
	// ******************************

	always_ff @(posedge clock) begin
		if (reset) begin
			retire_valid <= '0;
		end else begin
			retire_valid <= released.valid;
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < rob_pkg::lanes; i++) begin
			retire_dest[i] <= released.entries[i].dest;
			retire_value[i] <= released.entries[i].value;
		end
	end

	// ******************************
	// architectural register file
	// ******************************

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int r = 0; r < 2**isa_pkg::reg_index_width; r++) begin
				arch_regs[r] <= '0;
			end
		end else begin
			for (int i = rob_pkg::lanes - 1; i >= 0; i--) begin // younger lane written last.
				if (released.valid[i]) begin
					arch_regs[released.entries[i].dest] <= released.entries[i].value;
				end
			end
		end
	end

	assign read_data = arch_regs[read_index];

endmodule

// ==== design/backend_top.sv ====
`timescale 1ns/1ps

module backend_top #(
	parameter int rob_depth = 8,
	localparam int tag_width = $clog2(rob_depth)
) (
	input logic clock,
	input logic reset,

	// instruction group in.
	input logic [rob_pkg::lanes-1:0] in_valid,
	input isa_pkg::instr_word_t [rob_pkg::lanes-1:0] in_words,
	output logic in_ready,

	// results from execution units.
	input logic [rob_pkg::lanes-1:0] complete_valid,
	input logic [rob_pkg::lanes-1:0][tag_width-1:0] complete_tag,
	input logic [rob_pkg::lanes-1:0][rob_pkg::value_width-1:0] complete_value,

	output logic [rob_pkg::lanes-1:0] alloc_valid,
	output logic [rob_pkg::lanes-1:0][tag_width-1:0] alloc_tag,

	output logic [rob_pkg::lanes-1:0] retire_valid,
	output logic [rob_pkg::lanes-1:0][isa_pkg::reg_index_width-1:0] retire_dest,
	output logic [rob_pkg::lanes-1:0][rob_pkg::value_width-1:0] retire_value,

	input logic [isa_pkg::reg_index_width-1:0] read_index,
	output logic [rob_pkg::value_width-1:0] read_data
);

	alloc_if #(.rob_depth(rob_depth)) alloc_bus ();
	retire_if retire_bus ();

	dispatch_stage u_dispatch (
		.clock    (clock),
		.reset    (reset),
		.in_valid (in_valid),
		.in_words (in_words),
		.in_ready (in_ready),
		.alloc    (alloc_bus.producer)
	);

	reorder_buffer #(.rob_depth(rob_depth)) u_rob (
		.clock          (clock),
		.reset          (reset),
		.alloc          (alloc_bus.consumer),
		.complete_valid (complete_valid),
		.complete_tag   (complete_tag),
		.complete_value (complete_value),
		.alloc_valid    (alloc_valid),
		.alloc_tag      (alloc_tag),
		.released       (retire_bus.producer)
	);

	retire_stage u_retire (
		.clock        (clock),
		.reset        (reset),
		.released     (retire_bus.consumer),
		.retire_valid (retire_valid),
		.retire_dest  (retire_dest),
		.retire_value (retire_value),
		.read_index   (read_index),
		.read_data    (read_data)
	);

endmodule

// ==== testbench/tb_backend_assertions.sv ====
`timescale 1ns/1ps

module tb_backend_assertions (
	input logic clock,
	input logic reset,
	input logic in_ready,
	input logic [rob_pkg::lanes-1:0] alloc_valid,
	input logic [rob_pkg::lanes-1:0] retire_valid
);

	// ******************************
	// retirement shape
	// ******************************

	property retire_from_oldest;
		@(posedge clock) disable iff (reset)
		retire_valid inside {3'b000, 3'b100, 3'b110, 3'b111};
	endproperty

	assert property (retire_from_oldest)
		else $error("retire_valid lanes are not contiguous from lane 2");

	// ******************************
	// reset behavior
	// ******************************

	// state is known only after the first reset edge.
	assert property (@(posedge clock) (reset && $past(reset)) |-> alloc_valid == '0)
		else $error("alloc_valid set while reset is high");

	assert property (@(posedge clock) $fell(reset) |-> in_ready)
		else $error("in_ready low in the first cycle after reset");

endmodule

bind backend_top tb_backend_assertions assertion_checks (
	.clock        (clock),
	.reset        (reset),
	.in_ready     (in_ready),
	.alloc_valid  (alloc_valid),
	.retire_valid (retire_valid)
);

// ==== testbench/tb_backend.sv ====
`timescale 1ns/1ps

module tb_backend;

	localparam int rob_depth = 8;
	localparam int tag_width = $clog2(rob_depth);
	localparam int lanes = rob_pkg::lanes;
	localparam int num_rows = 13;
	localparam int row_cycle_bound = 40;
	localparam int cycle_limit = (num_rows + 2) * row_cycle_bound;

	typedef enum int {at_once, held, reversed} policy_t;

	typedef struct {
		logic [lanes-1:0] valid;
		logic [lanes-1:0][isa_pkg::word_width-1:0] words; // lane 2 is the oldest.
		policy_t policy;
		int hold;
	} row_t;

	logic clock;
	logic reset;
	logic [lanes-1:0] in_valid;
	isa_pkg::instr_word_t [lanes-1:0] in_words;
	logic in_ready;
	logic [lanes-1:0] complete_valid;
	logic [lanes-1:0][tag_width-1:0] complete_tag;
	logic [lanes-1:0][rob_pkg::value_width-1:0] complete_value;
	logic [lanes-1:0] alloc_valid;
	logic [lanes-1:0][tag_width-1:0] alloc_tag;
	logic [lanes-1:0] retire_valid;
	logic [lanes-1:0][isa_pkg::reg_index_width-1:0] retire_dest;
	logic [lanes-1:0][rob_pkg::value_width-1:0] retire_value;
	logic [isa_pkg::reg_index_width-1:0] read_index;
	logic [rob_pkg::value_width-1:0] read_data;

	row_t rows [num_rows];
	logic [31:0] lfsr_state;
	logic [15:0] shadow_regs [16];
	int exp_dest [$];
	logic [15:0] exp_value [$];
	int pend_tag [$];
	int pend_due [$];
	logic [15:0] pend_value [$];
	int sent_rows [$];
	int touched [$];
	int cycle_count, alloc_total, retire_total, max_in_flight, stall_cycles, next_tag;

	backend_top #(.rob_depth(rob_depth)) UUT (
		.clock(clock), .reset(reset), .in_valid(in_valid), .in_words(in_words),
		.in_ready(in_ready), .complete_valid(complete_valid), .complete_tag(complete_tag),
		.complete_value(complete_value), .alloc_valid(alloc_valid), .alloc_tag(alloc_tag),
		.retire_valid(retire_valid), .retire_dest(retire_dest), .retire_value(retire_value),
		.read_index(read_index), .read_data(read_data)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// ******************************
	// helpers
	// ******************************

	function automatic logic [15:0] imm_word(input int dest, input int imm);
		return {isa_pkg::op_li, 4'(dest), 8'(imm)};
	endfunction

	function automatic logic [15:0] reg_word(input int dest);
		return {isa_pkg::op_add, 4'(dest), 4'h1, 4'h2};
	endfunction

	function automatic logic [15:0] random_value();
		logic [15:0] value;
		for (int b = 0; b < 16; b++) begin
			value[b] = lfsr_state[0];
			lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
		end
		return value;
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at %0t ns", $time);
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			stop_with_failure($sformatf("MISMATCH at %0t ns: %s, expected %0h, got %0h",
				$time, what, expected, actual));
		end
	endtask

	task automatic set_row(input int r, input logic [2:0] valid, input logic [15:0] w2,
			input logic [15:0] w1, input logic [15:0] w0, input policy_t policy, input int hold);
		rows[r].valid = valid;
		rows[r].words = {w2, w1, w0};
		rows[r].policy = policy;
		rows[r].hold = hold;
	endtask

	task automatic check_registers();
		for (int r = 0; r < 16; r++) begin
			read_index = 4'(r);
			#1;
			check_value(read_data, shadow_regs[r], $sformatf("register r%0d", r));
		end
	endtask

	// ******************************
	// reference model
	// ******************************

	task automatic record_allocation();
		int row;
		int reg_count;
		logic [15:0] value;
		if (alloc_valid == '0) return;
		if (sent_rows.size() == 0) stop_with_failure("allocation seen with no group sent");
		row = sent_rows.pop_front();
		check_value(alloc_valid, rows[row].valid, "alloc_valid");
		reg_count = 0;
		for (int lane = lanes - 1; lane >= 0; lane--) begin
			if (rows[row].valid[lane]) begin
				check_value(alloc_tag[lane], next_tag, "alloc_tag");
				next_tag = (next_tag + 1) % rob_depth;
				exp_dest.push_back(rows[row].words[lane][11:8]);
				if (rows[row].words[lane][15]) begin
					exp_value.push_back({8'h00, rows[row].words[lane][7:0]});
				end else begin
					value = random_value();
					exp_value.push_back(value);
					pend_tag.push_back(alloc_tag[lane]);
					pend_value.push_back(value);
					reg_count++;
					case (rows[row].policy)
						at_once: pend_due.push_back(cycle_count + 1);
						held: pend_due.push_back(cycle_count + rows[row].hold);
						default: pend_due.push_back(cycle_count + 4 - reg_count); // youngest first.
					endcase
				end
			end
		end
		alloc_total += $countones(alloc_valid);
	endtask

	task automatic check_retirement();
		int d;
		logic [15:0] value;
		for (int lane = lanes - 1; lane >= 0; lane--) begin
			if (retire_valid[lane]) begin
				if (exp_dest.size() == 0) stop_with_failure("retirement seen with no commit expected");
				d = exp_dest.pop_front();
				value = exp_value.pop_front();
				check_value(retire_dest[lane], d, $sformatf("retire_dest lane %0d", lane));
				check_value(retire_value[lane], value, $sformatf("retire_value lane %0d", lane));
				shadow_regs[d] = value; // older lanes first, so the younger one wins.
				touched.push_back(d);
				retire_total++;
			end
		end
	endtask

	task automatic drive_completions();
		int i;
		int n;
		complete_valid = '0;
		i = 0;
		n = 0;
		while (i < pend_due.size()) begin
			if (pend_due[i] <= cycle_count && n < lanes) begin
				complete_valid[n] = 1'b1;
				complete_tag[n] = tag_width'(pend_tag[i]);
				complete_value[n] = pend_value[i];
				pend_due.delete(i);
				pend_tag.delete(i);
				pend_value.delete(i);
				n++;
			end else begin
				i++;
			end
		end
	endtask

	// one clock cycle; row -1 leaves the input group empty.
	task automatic run_cycle(input int row, output logic taken);
		int in_flight;
		int d;
		@(negedge clock);
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			stop_with_failure($sformatf("timeout: run not finished after %0d cycles", cycle_limit));
		end
		check_retirement();
		in_flight = alloc_total - retire_total; // entries the buffer holds now.
		if (in_flight > rob_depth) stop_with_failure("buffer holds more entries than its depth");
		if (in_flight > max_in_flight) max_in_flight = in_flight;
		record_allocation();
		taken = (row >= 0) && in_ready;
		if (row >= 0) begin
			in_valid = rows[row].valid;
			in_words = rows[row].words;
			if (!in_ready) stall_cycles++;
		end else begin
			in_valid = '0;
		end
		if (taken) sent_rows.push_back(row);
		drive_completions();
		while (touched.size() > 0) begin
			d = touched.pop_front();
			read_index = 4'(d);
			#1;
			check_value(read_data, shadow_regs[d], $sformatf("read_data r%0d", d));
		end
	endtask

	// ******************************
	// stimulus
	// ******************************

	initial begin
		logic taken;
		reset = 1'b1;
		in_valid = '0;
		in_words = '0;
		complete_valid = '0;
		complete_tag = '0;
		complete_value = '0;
		read_index = '0;
		lfsr_state = 32'hb7d9b29b;
		for (int r = 0; r < 16; r++) shadow_regs[r] = '0;
		set_row(0, 3'b111, imm_word(1, 'h11), imm_word(2, 'h22), imm_word(3, 'h33), at_once, 0);
		set_row(1, 3'b110, imm_word(4, 'h44), imm_word(5, 'ha5), reg_word(0), at_once, 0);
		set_row(2, 3'b111, reg_word(6), reg_word(7), reg_word(8), reversed, 0);
		set_row(3, 3'b111, reg_word(9), reg_word(10), reg_word(11), held, 5);
		set_row(4, 3'b111, reg_word(12), imm_word(13, 'h7f), reg_word(14), at_once, 0);
		set_row(5, 3'b110, reg_word(1), reg_word(2), reg_word(0), held, 2);
		set_row(6, 3'b111, reg_word(3), reg_word(4), reg_word(5), held, 20); // fills the buffer.
		set_row(7, 3'b111, reg_word(6), reg_word(7), reg_word(8), held, 20);
		set_row(8, 3'b110, reg_word(9), reg_word(10), reg_word(0), held, 20);
		set_row(9, 3'b111, imm_word(11, 'hc1), imm_word(12, 'hc2), imm_word(13, 'hc3), at_once, 0);
		set_row(10, 3'b111, imm_word(2, 'h01), reg_word(2), imm_word(2, 'h03), reversed, 0);
		set_row(11, 3'b111, reg_word(5), imm_word(5, 'h55), reg_word(5), at_once, 0);
		set_row(12, 3'b100, imm_word(0, 'hff), reg_word(0), reg_word(0), at_once, 0);
		repeat (3) @(negedge clock);
		reset = 1'b0;
		check_value(in_ready, 1'b1, "in_ready after reset");
		check_value(retire_valid, '0, "retire_valid after reset");
		check_registers();
		repeat (2) run_cycle(-1, taken);
		for (int r = 0; r < num_rows; r++) begin
			taken = 1'b0;
			while (!taken) run_cycle(r, taken);
		end
		while (exp_dest.size() > 0 || sent_rows.size() > 0 || pend_due.size() > 0) begin
			run_cycle(-1, taken);
		end
		repeat (2) run_cycle(-1, taken);
		check_registers();
		check_value(max_in_flight, rob_depth, "peak buffer occupancy");
		check_value(stall_cycles > 0, 1'b1, "in_ready low while the buffer was full");
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== sources.f ====
design/isa_pkg.sv
design/rob_pkg.sv
design/rob_ifs.sv
design/dispatch_stage.sv
design/reorder_buffer.sv
design/retire_stage.sv
design/backend_top.sv
testbench/tb_backend_assertions.sv
testbench/tb_backend.sv
